//--- all.f
+incdir+verilog
+incdir+verification
verilog/fpu_pkg.sv
verilog/fpu_f32_add.sv
verilog/fpu_f32_round.sv
verilog/fpu_f32_unit.sv
verification/fpu_tb.sv

//--- run.sh
#!/bin/sh
# Compile the unit and its testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal --top-module fpu_tb -f all.f -o fpu_sim \
	&& ./obj_dir/fpu_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "All checks passed" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

//--- verification/fpu_tb_tasks.svh
// ======================================================================
// Testbench helpers, included inside the testbench module
// LFSR, reference model, compare tasks and the directed tests
// ======================================================================
`ifndef FPU_TB_TASKS_SVH
`define FPU_TB_TASKS_SVH

// Flag patterns, ordered invalid, overflow, inexact
localparam fpu_pkg::fpu_flags_t FL_NONE    = 3'b000;
localparam fpu_pkg::fpu_flags_t FL_INEXACT = 3'b001;
localparam fpu_pkg::fpu_flags_t FL_OVF     = 3'b011;
localparam fpu_pkg::fpu_flags_t FL_INVALID = 3'b100;

// ======================================================================
// Random numbers and failure reporting
// ======================================================================
// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic rand_bit();
	logic fb;
	fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
	lfsr = {lfsr[30:0], fb};
	return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
		v = {v[30:0], rand_bit()};
	return v;
endfunction

task automatic report_failure(input string msg);
	$display("%s", msg);
	$display("Checks failed");
	$fatal(1);
endtask

// ======================================================================
// Reference model
// ======================================================================
function automatic logic is_nan(input fpu_pkg::f32_t f);
	return (f[30:23] == 8'hFF) && (f[22:0] != '0);
endfunction

function automatic logic is_inf(input fpu_pkg::f32_t f);
	return (f[30:23] == 8'hFF) && (f[22:0] == '0);
endfunction

// Exact value as a double, subnormals read as zero
function automatic real to_real(input fpu_pkg::f32_t f);
	if (f[30:23] == 8'h00)
		return 0.0;
	return $bitstoreal({f[31], 11'(f[30:23]) + 11'd896, f[22:0], 29'b0});
endfunction

// Double to binary32, nearest even, nothing kept below the normal range
function automatic fpu_pkg::f32_t to_f32(input real v, output logic inexact);
	logic [63:0] d;
	logic [24:0] rnd;
	logic        guard;
	logic        rest;
	int          e;
	d     = $realtobits(v);
	guard = d[28];
	rest  = |d[27:0];
	// Hidden bit plus 23 kept bits, top bit catches the rounding carry
	rnd     = {2'b01, d[51:29]} + 25'(guard & (rest | d[29]));
	e       = int'(d[62:52]) - 896 + int'(rnd[24]);
	inexact = guard | rest;
	if (e >= 255) begin
		inexact = 1'b1;
		return {d[63], 8'hFF, 23'h0};
	end
	if (e < 1) begin
		inexact = 1'b1;
		return {d[63], 31'h0};
	end
	return {d[63], 8'(e), rnd[22:0]};
endfunction

function automatic fpu_pkg::fpu_rsp_t model(input fpu_pkg::fpu_req_t r);
	fpu_pkg::fpu_rsp_t e;
	fpu_pkg::f32_t     b;
	real               x;
	real               y;
	real               s;
	real               s_y;
	real               err;
	logic              inexact;
	b       = {r.b[31] ^ r.subtract, r.b[30:0]};
	e.tag   = r.tag;
	e.flags = FL_NONE;
	if (is_nan(r.a) || is_nan(b) || (is_inf(r.a) && is_inf(b) && r.a[31] != b[31])) begin
		e.result = `FPU_QNAN;
		e.flags  = FL_INVALID;
	end else if (is_inf(r.a)) begin
		e.result = r.a;
	end else if (is_inf(b)) begin
		e.result = b;
	end else begin
		x = to_real(r.a);
		y = to_real(b);
		s = x + y;
		// Error term of the double sum, nonzero when bits fell below double precision
		s_y = s - x;
		err = (x - (s - s_y)) + (y - s_y);
		if (s == 0.0) begin
			// Only two negative zeros give a negative zero
			e.result = {r.a[31] & b[31], 31'h0};
		end else begin
			e.result         = to_f32(s, inexact);
			e.flags.inexact  = inexact | (err != 0.0);
			e.flags.overflow = is_inf(e.result);
		end
	end
	return e;
endfunction

// ======================================================================
// Compare tasks
// ======================================================================
task automatic check_f32(input string what, input fpu_pkg::f32_t expected,
		input fpu_pkg::f32_t actual);
	if (actual !== expected)
		report_failure($sformatf("Mismatch in test %s, %s: expected %h, actual %h",
			test_name, what, expected, actual));
endtask

task automatic check_flags(input string what, input fpu_pkg::fpu_flags_t expected,
		input fpu_pkg::fpu_flags_t actual);
	if (actual !== expected)
		report_failure($sformatf("Mismatch in test %s, %s: expected %b, actual %b",
			test_name, what, expected, actual));
endtask

task automatic check_tag(input string what, input fpu_pkg::tag_t expected,
		input fpu_pkg::tag_t actual);
	if (actual !== expected)
		report_failure($sformatf("Mismatch in test %s, %s: expected %h, actual %h",
			test_name, what, expected, actual));
endtask

task automatic check_cycles(input string what, input int expected, input int actual);
	if (actual != expected)
		report_failure($sformatf("Mismatch in test %s, %s: expected %0d, actual %0d",
			test_name, what, expected, actual));
endtask

// ======================================================================
// Driving
// ======================================================================
// Hold the request until the unit takes it
task automatic send_req(input fpu_pkg::fpu_req_t r, input fpu_pkg::fpu_rsp_t expected);
	exp_q.push_back(expected);
	@(negedge clk);
	req_valid = 1'b1;
	req       = r;
	do
		@(posedge clk);
	while (!req_ready);
endtask

task automatic drain();
	@(negedge clk);
	req_valid = 1'b0;
	while (exp_q.size() != 0)
		@(posedge clk);
endtask

task automatic send_model(input logic sub, input fpu_pkg::f32_t a, input fpu_pkg::f32_t b,
		input fpu_pkg::tag_t tag);
	fpu_pkg::fpu_req_t r;
	r = '{sub, a, b, tag};
	send_req(r, model(r));
endtask

// Hand-worked answer, also held against the model, one request at a time
task automatic send_known(input logic sub, input fpu_pkg::f32_t a, input fpu_pkg::f32_t b,
		input fpu_pkg::f32_t result, input fpu_pkg::fpu_flags_t flags);
	fpu_pkg::fpu_req_t r;
	fpu_pkg::fpu_rsp_t e;
	fpu_pkg::fpu_rsp_t m;
	r = '{sub, a, b, 4'h5};
	e = '{result, flags, 4'h5};
	m = model(r);
	check_f32("model result", result, m.result);
	check_flags("model flags", flags, m.flags);
	send_req(r, e);
	drain();
endtask

`endif

//--- verification/fpu_tb.sv
// ======================================================================
// Testbench of the pipelined binary32 add/subtract unit
// Directed tests checked against a double-precision model
// ======================================================================
`include "fpu_defines.svh"

module fpu_tb;

	localparam int CLK_PERIOD = 40;
	// Requests over all tests, sets the watchdog limit
	localparam int NUM_REQS = 225;
	localparam longint TIMEOUT = longint'(NUM_REQS * 40 + 200) * CLK_PERIOD;

	// DUT ports
	logic              clk;
	logic              reset;
	logic              req_valid;
	logic              req_ready;
	fpu_pkg::fpu_req_t req;
	logic              rsp_valid;
	logic              rsp_ready;
	fpu_pkg::fpu_rsp_t rsp;

	// Scoreboard, expected responses and accept cycles in request order
	fpu_pkg::fpu_rsp_t exp_q[$];
	int                acc_q[$];
	fpu_pkg::fpu_rsp_t expected;
	int                latency;

	// Monitor state
	int                cycle;
	int                first_acc;
	int                last_acc;
	int                stall_count;
	logic              held_valid;
	fpu_pkg::fpu_rsp_t held;

	// Test control
	logic [31:0]       lfsr;
	logic              ready_random;
	logic              check_lat;
	string             test_name;

	`include "fpu_tb_tasks.svh"

	fpu_f32_unit i_fpu_f32_unit (
		.clk       (clk),
		.reset     (reset),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Sink, random stalls only in the back-pressure test
	always @(negedge clk) begin
		if (ready_random)
			rsp_ready = rand_bit();
		else
			rsp_ready = 1'b1;
	end

	// ==================================================================
	// Monitor, sees both channels before the edge updates the DUT
	// ==================================================================
	always @(posedge clk) begin
		cycle++;
		if (!reset) begin
			if (req_valid && req_ready) begin
				acc_q.push_back(cycle);
				if (first_acc < 0)
					first_acc = cycle;
				last_acc = cycle;
			end
			// A stalled response comes back unchanged
			if (held_valid) begin
				if (!rsp_valid) begin
					report_failure("Response valid dropped while the sink stalled it");
				end else begin
					check_f32("held result", held.result, rsp.result);
					check_flags("held flags", held.flags, rsp.flags);
					check_tag("held tag", held.tag, rsp.tag);
				end
			end
			held_valid = rsp_valid && !rsp_ready;
			held       = rsp;
			if (held_valid)
				stall_count++;
			if (rsp_valid && rsp_ready) begin
				if (exp_q.size() == 0) begin
					report_failure("A response arrived with no request outstanding");
				end else begin
					expected = exp_q.pop_front();
					latency  = cycle - acc_q.pop_front();
					check_f32("result", expected.result, rsp.result);
					check_flags("flags", expected.flags, rsp.flags);
					check_tag("tag", expected.tag, rsp.tag);
					if (check_lat)
						check_cycles("latency", 2, latency);
				end
			end
		end
	end

	// Watchdog
	initial begin
		#(TIMEOUT);
		report_failure("Timeout, the tests did not finish in the expected time");
	end

	// ==================================================================
	// Test sequence
	// ==================================================================
	initial begin
		clk          = 1'b0;
		reset        = 1'b1;
		req_valid    = 1'b0;
		req          = '0;
		rsp_ready    = 1'b1;
		lfsr         = 32'h6242f997;
		ready_random = 1'b0;
		check_lat    = 1'b0;
		test_name    = "reset";
		cycle        = 0;
		first_acc    = -1;
		last_acc     = 0;
		stall_count  = 0;
		held_valid   = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Exact sums, flags clear, two cycles from accept to response
		test_name = "exact";
		check_lat = 1'b1;
		send_known(1'b0, 32'h3FC00000, 32'h40100000, 32'h40700000, FL_NONE);
		send_known(1'b1, 32'h40400000, 32'h40400000, 32'h00000000, FL_NONE);
		send_known(1'b0, 32'h3F800000, 32'hBF000000, 32'h3F000000, FL_NONE);
		send_known(1'b0, 32'hBFC00000, 32'h40100000, 32'h3F400000, FL_NONE);
		send_known(1'b1, 32'hC0000000, 32'h3FA00000, 32'hC0500000, FL_NONE);
		check_lat = 1'b0;

		// Ties go to even, just above a tie goes up
		test_name = "rounding";
		send_known(1'b0, 32'h3F800000, 32'h33800000, 32'h3F800000, FL_INEXACT);
		send_known(1'b0, 32'h3F800000, 32'h33C00000, 32'h3F800001, FL_INEXACT);
		send_known(1'b0, 32'h3F800001, 32'h33800000, 32'h3F800002, FL_INEXACT);
		send_known(1'b1, 32'h3F800000, 32'h33000000, 32'h3F800000, FL_INEXACT);

		test_name = "special";
		send_known(1'b0, 32'h7F800001, 32'h3F800000, `FPU_QNAN, FL_INVALID);
		send_known(1'b1, 32'h3F800000, 32'hFFC12345, `FPU_QNAN, FL_INVALID);
		send_known(1'b1, 32'h7F800000, 32'h7F800000, `FPU_QNAN, FL_INVALID);
		send_known(1'b0, 32'h7F800000, 32'hC0A00000, 32'h7F800000, FL_NONE);
		send_known(1'b1, 32'h40000000, 32'hFF800000, 32'h7F800000, FL_NONE);
		send_known(1'b0, 32'h7F7FFFFF, 32'h7F7FFFFF, 32'h7F800000, FL_OVF);
		send_known(1'b0, 32'h00000001, 32'h3F800000, 32'h3F800000, FL_NONE);
		send_known(1'b0, 32'h80400000, 32'h80000000, 32'h80000000, FL_NONE);

		test_backpressure();
		test_random();

		$display("All checks passed");
		$finish;
	end

	// Eight tagged requests while the sink stalls at random
	task automatic test_backpressure();
		fpu_pkg::f32_t a;
		fpu_pkg::f32_t b;
		test_name    = "backpressure";
		ready_random = 1'b1;
		stall_count  = 0;
		for (int i = 0; i < 8; i++) begin
			a = {1'b0, 8'(127 + i), 23'(i * 40503)};
			b = {i[1], 8'(125 + i / 2), 23'(i * 2221)};
			send_model(i[0], a, b, 4'(i));
		end
		drain();
		ready_random = 1'b0;
		if (stall_count == 0)
			report_failure("The sink never stalled a response in the back-pressure test");
	endtask

	// 200 random requests back to back, one accepted per cycle
	task automatic test_random();
		fpu_pkg::f32_t a;
		fpu_pkg::f32_t b;
		logic          sub;
		test_name = "random";
		first_acc = -1;
		for (int i = 0; i < 200; i++) begin
			a   = rand_bits(32);
			b   = rand_bits(32);
			sub = rand_bit();
			// Close exponents for half the pairs, so cancellation shows up
			if (rand_bit())
				b[30:23] = a[30:23] ^ 8'(rand_bits(3));
			send_model(sub, a, b, 4'(i));
		end
		drain();
		check_cycles("accept cycles", 199, last_acc - first_acc);
	endtask

endmodule

//--- verilog/fpu_defines.svh
// ======================================================================
// Shared constants of the binary32 add/subtract unit
// Included by the package and by every stage that needs a constant
// ======================================================================
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// Request tag width
`define FPU_TAG_W 4

// IEEE-754 binary32 exponent bias
`define FPU_EXP_BIAS 127

// The one quiet NaN that the unit ever produces
`define FPU_QNAN 32'h7FC00000

// Stored field widths of a binary32 value
`define FPU_FRAC_W 23
`define FPU_EXP_W 8

// Carry, hidden bit, 23 fraction bits, guard, round and sticky
`define FPU_MANT_W 28

`endif

//--- verilog/fpu_f32_add.sv
// ======================================================================
// Stage one of the binary32 unit, combinational add or subtract
// Produces an unrounded significand and exponent for the round stage
// ======================================================================
`include "fpu_defines.svh"

module fpu_f32_add (
	input  fpu_pkg::f32_t     a,
	input  fpu_pkg::f32_t     b,
	input  logic              subtract,
	input  fpu_pkg::tag_t     tag,
	output fpu_pkg::fpu_sum_t sum
);

	// Operand B with the subtract applied to its sign
	fpu_pkg::f32_t b_eff;

	// Unpacked fields
	logic                  a_s;
	logic                  b_s;
	logic [`FPU_EXP_W-1:0] a_e;
	logic [`FPU_EXP_W-1:0] b_e;
	fpu_pkg::frac_t        a_f;
	fpu_pkg::frac_t        b_f;

	// Operand classes
	logic a_zero;
	logic b_zero;
	logic a_inf;
	logic b_inf;
	logic a_nan;
	logic b_nan;

	// Significands and magnitudes after the flush
	fpu_pkg::mant_t a_m;
	fpu_pkg::mant_t b_m;
	logic [30:0]    a_mag;
	logic [30:0]    b_mag;
	logic           swap;

	// Larger and smaller operand after the swap
	logic                  big_s;
	logic                  small_s;
	logic [`FPU_EXP_W-1:0] big_e;
	logic [`FPU_EXP_W-1:0] small_e;
	logic [`FPU_EXP_W-1:0] exp_diff;
	fpu_pkg::mant_t        big_m;
	fpu_pkg::mant_t        small_m;

	// Alignment and the add itself
	fpu_pkg::mant_t shifted;
	fpu_pkg::mant_t aligned;
	fpu_pkg::mant_t result_m;
	logic           lost;
	logic           eff_sub;

	assign b_eff = {b[31] ^ subtract, b[30:0]};
	assign {a_s, a_e, a_f} = a;
	assign {b_s, b_e, b_f} = b_eff;

	// ==================================================================
	// Classify
	// ==================================================================
	// Exponent zero covers zero and subnormals, both act as signed zero
	assign a_zero = (a_e == '0);
	assign b_zero = (b_e == '0);
	assign a_inf  = (&a_e) & ~(|a_f);
	assign b_inf  = (&b_e) & ~(|b_f);
	assign a_nan  = (&a_e) & (|a_f);
	assign b_nan  = (&b_e) & (|b_f);

	// Hidden bit at 26, three low bits left for guard, round and sticky
	assign a_m = a_zero ? '0 : {2'b01, a_f, 3'b000};
	assign b_m = b_zero ? '0 : {2'b01, b_f, 3'b000};

	// Exponent and fraction together compare as a magnitude
	assign a_mag = a_zero ? '0 : a[30:0];
	assign b_mag = b_zero ? '0 : b_eff[30:0];
	assign swap  = (b_mag > a_mag);

	// ==================================================================
	// Swap, align, add
	// ==================================================================
	always_comb begin
		if (swap) begin
			big_s   = b_s;
			big_e   = b_e;
			big_m   = b_m;
			small_s = a_s;
			small_e = a_e;
			small_m = a_m;
		end else begin
			big_s   = a_s;
			big_e   = a_e;
			big_m   = a_m;
			small_s = b_s;
			small_e = b_e;
			small_m = b_m;
		end
	end

	assign exp_diff = big_e - small_e;

	// Shifts of 28 or more clear everything and leave all bits in lost
	assign shifted = small_m >> exp_diff;
	assign lost    = |(small_m & ~({`FPU_MANT_W{1'b1}} << exp_diff));
	assign aligned = {shifted[`FPU_MANT_W-1:1], shifted[0] | lost};

	// Big is never smaller, so the difference cannot wrap
	assign eff_sub  = big_s ^ small_s;
	assign result_m = eff_sub ? big_m - aligned : big_m + aligned;

	always_comb begin
		sum.tag         = tag;
		sum.exp         = {2'b00, big_e};
		sum.mant        = result_m;
		// Exact cancellation is +0, two like-signed zeros keep their sign
		sum.sign        = (eff_sub && result_m == '0) ? 1'b0 : big_s;
		sum.special     = 1'b0;
		sum.special_val = '0;
		sum.invalid     = 1'b0;
		if (a_nan || b_nan || (a_inf && b_inf && (a_s != b_s))) begin
			sum.special     = 1'b1;
			sum.special_val = `FPU_QNAN;
			sum.invalid     = 1'b1;
		end else if (a_inf) begin
			sum.special     = 1'b1;
			sum.special_val = a;
		end else if (b_inf) begin
			// Sign of B already carries the subtract
			sum.special     = 1'b1;
			sum.special_val = b_eff;
		end
	end

	// Finite operands, judged from the raw inputs, never take the special path
	always_comb begin
		if (!(&a[30:23]) && !(&b[30:23])) begin
			assert (!sum.special)
				else $error("special result for finite operands");
		end
	end

endmodule

//--- verilog/fpu_f32_round.sv
// ======================================================================
// Stage two of the binary32 unit, combinational normalize and round
// Turns the unrounded sum into a packed result with its status flags
// ======================================================================
`include "fpu_defines.svh"

module fpu_f32_round (
	input  fpu_pkg::fpu_sum_t sum,
	output fpu_pkg::fpu_rsp_t rsp
);

	// Largest biased exponent, reserved for infinity and NaN
	localparam int EXP_MAX = 2 * `FPU_EXP_BIAS + 1;

	// Normalize
	logic [4:0]     lz;
	logic [4:0]     shift;
	fpu_pkg::mant_t norm;
	fpu_pkg::exp_t  exp_n;

	// Round
	logic                  lsb;
	logic                  guard;
	logic                  rest;
	logic                  round_up;
	logic                  lost;
	logic [`FPU_FRAC_W+1:0] rnd;
	fpu_pkg::exp_t         exp_r;
	fpu_pkg::frac_t        frac_r;

	// Leading zeros of the working significand, 28 when it is zero
	function automatic logic [4:0] lead_zeros(input fpu_pkg::mant_t m);
		logic [4:0] n;
		logic       found;
		n     = 5'd0;
		found = 1'b0;
		for (int i = `FPU_MANT_W - 1; i >= 0; i--) begin
			if (!found) begin
				if (m[i])
					found = 1'b1;
				else
					n = n + 5'd1;
			end
		end
		return n;
	endfunction

	// ==================================================================
	// Normalize so that the leading one sits at bit 26
	// ==================================================================
	always_comb begin
		lz    = lead_zeros(sum.mant);
		shift = 5'd0;
		if (sum.mant[`FPU_MANT_W-1]) begin
			// Carry out of the add, one step right, folding into sticky
			norm  = {1'b0, sum.mant[27:2], sum.mant[1] | sum.mant[0]};
			exp_n = sum.exp + 10'd1;
		end else begin
			// Cancellation, shift left by the extra zeros
			shift = lz - 5'd1;
			norm  = sum.mant << shift;
			exp_n = sum.exp - {5'b00000, shift};
		end
	end

	// ==================================================================
	// Round to nearest, ties to even
	// ==================================================================
	assign lsb      = norm[3];
	assign guard    = norm[2];
	assign rest     = norm[1] | norm[0];
	assign round_up = guard & (rest | lsb);
	assign lost     = guard | rest;

	// Hidden bit and fraction, one spare bit for the rounding carry
	assign rnd   = {1'b0, norm[26:3]} + 25'(round_up);
	assign exp_r = exp_n + {9'b0, rnd[`FPU_FRAC_W+1]};
	// On a carry the fraction bits are all zero either way
	assign frac_r = rnd[`FPU_FRAC_W-1:0];

	// ==================================================================
	// Pack
	// ==================================================================
	always_comb begin
		rsp.tag   = sum.tag;
		rsp.flags = '0;
		if (sum.special) begin
			rsp.result        = sum.special_val;
			rsp.flags.invalid = sum.invalid;
		end else if (sum.mant == '0) begin
			// Exact zero, sign decided by stage one
			rsp.result = {sum.sign, 31'b0};
		end else if ($signed(exp_r) >= EXP_MAX) begin
			rsp.result         = {sum.sign, {`FPU_EXP_W{1'b1}}, {`FPU_FRAC_W{1'b0}}};
			rsp.flags.overflow = 1'b1;
			rsp.flags.inexact  = 1'b1;
		end else if ($signed(exp_r) < 1) begin
			// Below the normal range, flushed like a subnormal input
			rsp.result        = {sum.sign, 31'b0};
			rsp.flags.inexact = 1'b1;
		end else begin
			rsp.result        = {sum.sign, exp_r[`FPU_EXP_W-1:0], frac_r};
			rsp.flags.inexact = lost;
		end
	end

	// Only the canonical quiet NaN ever leaves the unit
	always_comb begin
		if ((&rsp.result[30:23]) && (|rsp.result[22:0])) begin
			assert (rsp.result == `FPU_QNAN)
				else $error("non-canonical NaN %h", rsp.result);
		end
	end

endmodule

//--- verilog/fpu_f32_unit.sv
// ======================================================================
// Two-stage pipelined binary32 add/subtract unit, top level
// Valid/ready on request and response, one result per cycle
// ======================================================================

module fpu_f32_unit (
	input  logic              clk,
	input  logic              reset,

	// Request channel
	input  logic              req_valid,
	output logic              req_ready,
	input  fpu_pkg::fpu_req_t req,

	// Response channel
	output logic              rsp_valid,
	input  logic              rsp_ready,
	output fpu_pkg::fpu_rsp_t rsp
);

	// Stage s1 holds the accepted request
	logic              s1_valid;
	fpu_pkg::fpu_req_t s1_req;

	// Stage s2 holds the unrounded sum
	logic              s2_valid;
	fpu_pkg::fpu_sum_t s2_sum;

	// Add stage output feeding s2
	fpu_pkg::fpu_sum_t add_sum;

	// A stage may load when empty or when its content moves on
	logic s1_ready;
	logic s2_ready;

	// ==================================================================
	// Stall chain
	// ==================================================================
	// Back-pressure ripples from rsp_ready through s2 and s1 to req_ready
	assign s2_ready  = ~s2_valid | rsp_ready;
	assign s1_ready  = ~s1_valid | s2_ready;
	assign req_ready = s1_ready;

	// Response comes straight out of s2 through the round stage
	assign rsp_valid = s2_valid;

	// Valid bits
	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (s2_ready)
				s2_valid <= s1_valid;
			if (s1_ready)
				s1_valid <= req_valid;
		end
	end

	// Payload, loaded only with valid data
	always_ff @(posedge clk) begin
		if (s1_ready && req_valid)
			s1_req <= req;
		if (s2_ready && s1_valid)
			s2_sum <= add_sum;
	end

	// ==================================================================
	// Datapath stages
	// ==================================================================
	fpu_f32_add i_fpu_f32_add (
		.a        (s1_req.a),
		.b        (s1_req.b),
		.subtract (s1_req.subtract),
		.tag      (s1_req.tag),
		.sum      (add_sum)
	);

	fpu_f32_round i_fpu_f32_round (
		.sum (s2_sum),
		.rsp (rsp)
	);

	// ==================================================================
	// Checks
	// ==================================================================
	// A stalled response stays valid and unchanged until taken
	assert property (@(posedge clk) disable iff (reset)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
		else $error("response changed while stalled");

	// Nothing comes out right after reset
	assert property (@(posedge clk) reset |=> !rsp_valid)
		else $error("response valid after reset");

endmodule

//--- verilog/fpu_pkg.sv
// ======================================================================
// Types shared by the stages of the binary32 add/subtract unit
// Referenced everywhere by scoped names
// ======================================================================
`include "fpu_defines.svh"

package fpu_pkg;

	// One binary32 value, sign then exponent then fraction
	typedef logic [`FPU_EXP_W+`FPU_FRAC_W:0] f32_t;

	// Working exponent
	// Two extra bits keep overflow and underflow visible until packing
	typedef logic [`FPU_EXP_W+1:0] exp_t;

	// Stored fraction without the hidden bit
	typedef logic [`FPU_FRAC_W-1:0] frac_t;

	// Working significand, layout as in the defines header
	typedef logic [`FPU_MANT_W-1:0] mant_t;

	// Request identifier, returned unchanged with the response
	typedef logic [`FPU_TAG_W-1:0] tag_t;

	// Status flags of one result, not sticky
	typedef struct packed {
		logic invalid;
		logic overflow;
		logic inexact;
	} fpu_flags_t;

	// Request as seen on the input channel
	typedef struct packed {
		logic subtract;
		f32_t a;
		f32_t b;
		tag_t tag;
	} fpu_req_t;

	// Unrounded sum between stage one and stage two
	typedef struct packed {
		logic  sign;
		exp_t  exp;
		mant_t mant;
		// Set when stage one already knows the answer
		logic  special;
		f32_t  special_val;
		logic  invalid;
		tag_t  tag;
	} fpu_sum_t;

	// Response as seen on the output channel
	typedef struct packed {
		f32_t       result;
		fpu_flags_t flags;
		tag_t       tag;
	} fpu_rsp_t;

endpackage
